/* design/pito_alu.sv */
module pito_alu (
    input  pito_pkg::rv32_data_t a,
    input  pito_pkg::rv32_data_t b,
    input  pito_pkg::alu_op_t    op,
    output pito_pkg::rv32_data_t result
);
    import pito_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = rv32_data_t'(lt_signed);
            ALU_SLTU: result = rv32_data_t'(lt_unsigned);
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = rv32_data_t'($signed(a) >>> shamt);
            default:  result = '0;
        endcase
    end

endmodule

/* design/pito_core.sv */
`include "pito_defs.svh"

module pito_core (
    input  logic                  clk,
    input  logic                  rst_n,
    output pito_pkg::imem_addr_t  imem_addr,
    input  pito_pkg::rv32_instr_t imem_rdata,
    output logic                  dmem_req,
    output logic                  dmem_we,
    output pito_pkg::dmem_addr_t  dmem_addr,
    output pito_pkg::rv32_data_t  dmem_wdata,
    input  pito_pkg::rv32_data_t  dmem_rdata
);
    import pito_pkg::*;

    hart_id_t      fetch_hart;
    rv32_pc_t      fetch_pc;
    // decode stage
    logic          dec_valid;
    hart_id_t      dec_hart;
    rv32_pc_t      dec_pc;
    rv32_opcode_t  dec_opcode;
    rv32_reg_idx_t dec_rs1;
    rv32_reg_idx_t dec_rs2;
    rv32_reg_idx_t dec_rd;
    rv32_data_t    dec_imm;
    alu_op_t       dec_alu_op;
    logic          dec_use_imm;
    rv32_data_t    dec_rs1_val;
    rv32_data_t    dec_rs2_val;
    // execute stage
    logic          ex_valid;
    hart_id_t      ex_hart;
    rv32_pc_t      ex_pc;
    rv32_opcode_t  ex_opcode;
    rv32_reg_idx_t ex_rd;
    rv32_data_t    ex_imm;
    alu_op_t       ex_alu_op;
    logic          ex_use_imm;
    rv32_data_t    ex_rs1_val;
    rv32_data_t    ex_rs2_val;
    rv32_data_t    ex_alu_b;
    rv32_data_t    ex_alu_res;
    // memory stage
    logic          mem_valid;
    hart_id_t      mem_hart;
    rv32_pc_t      mem_pc;
    rv32_opcode_t  mem_opcode;
    rv32_reg_idx_t mem_rd;
    rv32_data_t    mem_imm;
    rv32_data_t    mem_rs1_val;
    rv32_data_t    mem_rs2_val;
    rv32_data_t    mem_alu_res;
    rv32_pc_t      mem_next_pc;
    rv32_data_t    mem_link;
    // write stage
    logic          wb_valid;
    hart_id_t      wb_hart;
    rv32_opcode_t  wb_opcode;
    rv32_reg_idx_t wb_rd;
    rv32_data_t    wb_imm;
    rv32_data_t    wb_link;
    rv32_data_t    wb_alu_res;
    rv32_data_t    wb_data;
    logic          wb_wen;

    //==========================================================================
    // fetch, the pc of the scheduled hart goes straight to the imem
    //==========================================================================
    pito_fetch u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_hart (fetch_hart),
        .fetch_pc   (fetch_pc),
        .pc_wen     (mem_valid),
        .pc_hart    (mem_hart),
        .pc_next    (mem_next_pc)
    );

    assign imem_addr = fetch_pc[`PITO_IMEM_ADDR_W+1:2];

    //==========================================================================
    // decode, instruction arrives from the sram this cycle
    //==========================================================================
    pito_decoder u_decoder (
        .instr   (imem_rdata),
        .opcode  (dec_opcode),
        .rs1     (dec_rs1),
        .rs2     (dec_rs2),
        .rd      (dec_rd),
        .imm     (dec_imm),
        .alu_op  (dec_alu_op),
        .use_imm (dec_use_imm)
    );

    pito_regfile u_regfile (
        .clk     (clk),
        .rd_hart (dec_hart),
        .ra1     (dec_rs1),
        .rd1     (dec_rs1_val),
        .ra2     (dec_rs2),
        .rd2     (dec_rs2_val),
        .wen     (wb_wen),
        .wr_hart (wb_hart),
        .wa      (wb_rd),
        .wd      (wb_data)
    );

    //==========================================================================
    // execute and memory
    //==========================================================================
    assign ex_alu_b = ex_use_imm ? ex_imm : ex_rs2_val;

    pito_alu u_alu (
        .a      (ex_rs1_val),
        .b      (ex_alu_b),
        .op     (ex_alu_op),
        .result (ex_alu_res)
    );

    pito_next_pc u_next_pc (
        .opcode   (mem_opcode),
        .pc       (mem_pc),
        .rs1_val  (mem_rs1_val),
        .rs2_val  (mem_rs2_val),
        .imm      (mem_imm),
        .next_pc  (mem_next_pc),
        .link_val (mem_link)
    );

    // word addressed data memory, low address bits dropped
    assign dmem_req   = mem_valid && (mem_opcode inside {OP_LW, OP_SW});
    assign dmem_we    = mem_valid && (mem_opcode == OP_SW);
    assign dmem_addr  = mem_alu_res[`PITO_DMEM_ADDR_W+1:2];
    assign dmem_wdata = mem_rs2_val;

    //==========================================================================
    // register write
    //==========================================================================
    always_comb begin
        case (wb_opcode)
            OP_LUI:          wb_data = wb_imm;
            OP_JAL, OP_JALR: wb_data = wb_link;
            OP_LW:           wb_data = dmem_rdata;
            default:         wb_data = wb_alu_res;
        endcase
    end

    assign wb_wen = wb_valid && !(wb_opcode inside {OP_NOP, OP_SW, OP_BEQ, OP_BNE,
                                                    OP_BLT, OP_BGE, OP_BLTU, OP_BGEU});

    // a slot enters the pipe every cycle once reset is released
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            dec_valid <= 1'b1;
            ex_valid  <= dec_valid;
            mem_valid <= ex_valid;
            wb_valid  <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        dec_hart    <= fetch_hart;
        dec_pc      <= fetch_pc;

        ex_hart     <= dec_hart;
        ex_pc       <= dec_pc;
        ex_opcode   <= dec_opcode;
        ex_rd       <= dec_rd;
        ex_imm      <= dec_imm;
        ex_alu_op   <= dec_alu_op;
        ex_use_imm  <= dec_use_imm;
        ex_rs1_val  <= dec_rs1_val;
        ex_rs2_val  <= dec_rs2_val;

        mem_hart    <= ex_hart;
        mem_pc      <= ex_pc;
        mem_opcode  <= ex_opcode;
        mem_rd      <= ex_rd;
        mem_imm     <= ex_imm;
        mem_rs1_val <= ex_rs1_val;
        mem_rs2_val <= ex_rs2_val;
        mem_alu_res <= ex_alu_res;

        wb_hart     <= mem_hart;
        wb_opcode   <= mem_opcode;
        wb_rd       <= mem_rd;
        wb_imm      <= mem_imm;
        wb_link     <= mem_link;
        wb_alu_res  <= mem_alu_res;
    end

endmodule

/* design/pito_decoder.sv */
module pito_decoder (
    input  pito_pkg::rv32_instr_t   instr,
    output pito_pkg::rv32_opcode_t  opcode,
    output pito_pkg::rv32_reg_idx_t rs1,
    output pito_pkg::rv32_reg_idx_t rs2,
    output pito_pkg::rv32_reg_idx_t rd,
    output pito_pkg::rv32_data_t    imm,
    output pito_pkg::alu_op_t       alu_op,
    output logic                    use_imm
);
    import pito_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    rv32_data_t imm_i;
    rv32_data_t imm_s;
    rv32_data_t imm_b;
    rv32_data_t imm_u;
    rv32_data_t imm_j;

    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // sign-extended immediates of the five formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        opcode  = OP_NOP;
        imm     = imm_i;
        use_imm = 1'b0;
        case (instr[6:0])
            7'b0110011: begin
                case ({funct7, funct3})
                    10'b0000000_000: opcode = OP_ADD;
                    10'b0100000_000: opcode = OP_SUB;
                    10'b0000000_001: opcode = OP_SLL;
                    10'b0000000_010: opcode = OP_SLT;
                    10'b0000000_011: opcode = OP_SLTU;
                    10'b0000000_100: opcode = OP_XOR;
                    10'b0000000_101: opcode = OP_SRL;
                    10'b0100000_101: opcode = OP_SRA;
                    10'b0000000_110: opcode = OP_OR;
                    10'b0000000_111: opcode = OP_AND;
                    default:         opcode = OP_NOP;
                endcase
            end
            7'b0010011: begin
                use_imm = 1'b1;
                case (funct3)
                    3'b000: opcode = OP_ADDI;
                    3'b010: opcode = OP_SLTI;
                    3'b011: opcode = OP_SLTIU;
                    3'b100: opcode = OP_XORI;
                    3'b110: opcode = OP_ORI;
                    3'b111: opcode = OP_ANDI;
                    3'b001: opcode = (funct7 == 7'b0000000) ? OP_SLLI : OP_NOP;
                    default: begin
                        // srli and srai share funct3 and differ in bit 30
                        if (funct7 == 7'b0000000) begin
                            opcode = OP_SRLI;
                        end else if (funct7 == 7'b0100000) begin
                            opcode = OP_SRAI;
                        end
                    end
                endcase
            end
            7'b0110111: begin
                opcode = OP_LUI;
                imm    = imm_u;
            end
            7'b0000011: begin
                opcode  = (funct3 == 3'b010) ? OP_LW : OP_NOP;
                use_imm = 1'b1;
            end
            7'b0100011: begin
                opcode  = (funct3 == 3'b010) ? OP_SW : OP_NOP;
                imm     = imm_s;
                use_imm = 1'b1;
            end
            7'b1100011: begin
                imm = imm_b;
                case (funct3)
                    3'b000:  opcode = OP_BEQ;
                    3'b001:  opcode = OP_BNE;
                    3'b100:  opcode = OP_BLT;
                    3'b101:  opcode = OP_BGE;
                    3'b110:  opcode = OP_BLTU;
                    3'b111:  opcode = OP_BGEU;
                    default: opcode = OP_NOP;
                endcase
            end
            7'b1101111: begin
                opcode = OP_JAL;
                imm    = imm_j;
            end
            7'b1100111: begin
                opcode = (funct3 == 3'b000) ? OP_JALR : OP_NOP;
            end
            default: opcode = OP_NOP;
        endcase
    end

    // loads and stores use the adder for their address
    always_comb begin
        case (opcode)
            OP_SUB:            alu_op = ALU_SUB;
            OP_AND, OP_ANDI:   alu_op = ALU_AND;
            OP_OR, OP_ORI:     alu_op = ALU_OR;
            OP_XOR, OP_XORI:   alu_op = ALU_XOR;
            OP_SLT, OP_SLTI:   alu_op = ALU_SLT;
            OP_SLTU, OP_SLTIU: alu_op = ALU_SLTU;
            OP_SLL, OP_SLLI:   alu_op = ALU_SLL;
            OP_SRL, OP_SRLI:   alu_op = ALU_SRL;
            OP_SRA, OP_SRAI:   alu_op = ALU_SRA;
            default:           alu_op = ALU_ADD;
        endcase
    end

endmodule

/* design/pito_defs.svh */
`ifndef PITO_DEFS_SVH
`define PITO_DEFS_SVH

// hart scheduling
`define PITO_NUM_HARTS 8
`define PITO_HART_W 3

// datapath and register file
`define PITO_XLEN 32
`define PITO_NUM_REGS 32

// word address widths of the two memories
`define PITO_IMEM_ADDR_W 10
`define PITO_DMEM_ADDR_W 10

// hart h starts executing at byte address h * stride
`define PITO_HART_CODE_STRIDE 256

`endif

/* design/pito_fetch.sv */
`include "pito_defs.svh"

module pito_fetch (
    input  logic               clk,
    input  logic               rst_n,
    output pito_pkg::hart_id_t fetch_hart,
    output pito_pkg::rv32_pc_t fetch_pc,
    input  logic               pc_wen,
    input  pito_pkg::hart_id_t pc_hart,
    input  pito_pkg::rv32_pc_t pc_next
);
    import pito_pkg::*;

    // one program counter per hart
    rv32_pc_t pc_bank [`PITO_NUM_HARTS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_hart <= '0;
            // every hart begins in its own code region
            for (int h = 0; h < `PITO_NUM_HARTS; h++) begin
                pc_bank[h] <= rv32_pc_t'(h * `PITO_HART_CODE_STRIDE);
            end
        end else begin
            // strict round robin, one hart per cycle
            fetch_hart <= fetch_hart + 1'b1;
            if (pc_wen) begin
                pc_bank[pc_hart] <= pc_next;
            end
        end
    end

    assign fetch_pc = pc_bank[fetch_hart];

endmodule

/* design/pito_next_pc.sv */
module pito_next_pc (
    input  pito_pkg::rv32_opcode_t opcode,
    input  pito_pkg::rv32_pc_t     pc,
    input  pito_pkg::rv32_data_t   rs1_val,
    input  pito_pkg::rv32_data_t   rs2_val,
    input  pito_pkg::rv32_data_t   imm,
    output pito_pkg::rv32_pc_t     next_pc,
    output pito_pkg::rv32_data_t   link_val
);
    import pito_pkg::*;

    logic     taken;
    rv32_pc_t pc_plus4;

    assign pc_plus4 = pc + 32'd4;

    // branch conditions
    always_comb begin
        case (opcode)
            OP_BEQ:  taken = (rs1_val == rs2_val);
            OP_BNE:  taken = (rs1_val != rs2_val);
            OP_BLT:  taken = ($signed(rs1_val) < $signed(rs2_val));
            OP_BGE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            OP_BLTU: taken = (rs1_val < rs2_val);
            OP_BGEU: taken = (rs1_val >= rs2_val);
            OP_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // jalr target has bit 0 cleared
    always_comb begin
        if (opcode == OP_JALR) begin
            next_pc = (rs1_val + imm) & ~32'd1;
        end else if (taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

    assign link_val = rv32_data_t'(pc_plus4);

endmodule

/* design/pito_pkg.sv */
`include "pito_defs.svh"

package pito_pkg;

    typedef logic [`PITO_XLEN-1:0] rv32_data_t;
    typedef logic [31:0] rv32_instr_t;
    typedef logic [`PITO_XLEN-1:0] rv32_pc_t;
    typedef logic [$clog2(`PITO_NUM_REGS)-1:0] rv32_reg_idx_t;
    typedef logic [`PITO_HART_W-1:0] hart_id_t;
    typedef logic [`PITO_IMEM_ADDR_W-1:0] imem_addr_t;
    typedef logic [`PITO_DMEM_ADDR_W-1:0] dmem_addr_t;

    // decoded instructions, anything unsupported becomes OP_NOP
    typedef enum logic [5:0] {
        OP_NOP,
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA,
        OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI,
        OP_SLTIU, OP_SLLI, OP_SRLI, OP_SRAI,
        OP_LUI,
        OP_LW, OP_SW,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JAL, OP_JALR
    } rv32_opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB,
        ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_t;

endpackage

/* design/pito_regfile.sv */
`include "pito_defs.svh"

module pito_regfile (
    input  logic                    clk,
    input  pito_pkg::hart_id_t      rd_hart,
    input  pito_pkg::rv32_reg_idx_t ra1,
    output pito_pkg::rv32_data_t    rd1,
    input  pito_pkg::rv32_reg_idx_t ra2,
    output pito_pkg::rv32_data_t    rd2,
    input  logic                    wen,
    input  pito_pkg::hart_id_t      wr_hart,
    input  pito_pkg::rv32_reg_idx_t wa,
    input  pito_pkg::rv32_data_t    wd
);
    import pito_pkg::*;

    // one bank of 32 registers per hart
    rv32_data_t regs [`PITO_NUM_HARTS][`PITO_NUM_REGS];

    always_ff @(posedge clk) begin
        if (wen && (wa != '0)) begin
            regs[wr_hart][wa] <= wd;
        end
    end

    // x0 is hardwired to zero
    assign rd1 = (ra1 == '0) ? '0 : regs[rd_hart][ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[rd_hart][ra2];

endmodule

/* pito_core.f */
+incdir+design
design/pito_pkg.sv
design/pito_fetch.sv
design/pito_decoder.sv
design/pito_regfile.sv
design/pito_alu.sv
design/pito_next_pc.sv
design/pito_core.sv
tb/pito_core_properties.sv
tb/pito_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module pito_core_tb -f pito_core.f -o pito_core_sim
./obj_dir/pito_core_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi

/* tb/pito_core_properties.sv */
module pito_core_properties (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 dmem_req,
    input logic                 dmem_we,
    input pito_pkg::dmem_addr_t dmem_addr,
    input pito_pkg::rv32_data_t dmem_wdata,
    input pito_pkg::imem_addr_t imem_addr
);
    import pito_pkg::*;

    // a store puts a known address and value on the port
    a_store_known: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_we |-> !$isunknown({dmem_addr, dmem_wdata}))
        else $error("dmem_we high with unknown dmem_addr or dmem_wdata");

    // pipe is empty in the first cycle out of reset
    a_no_req_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !dmem_req)
        else $error("dmem_req high in the first cycle after reset");

    a_imem_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(imem_addr))
        else $error("imem_addr unknown");

endmodule

bind pito_core pito_core_properties u_properties (.*);

/* tb/pito_core_tb.sv */
`include "pito_defs.svh"

module pito_core_tb;
    import pito_pkg::*;

    localparam int RUN_CYCLES = 300;
    localparam int CYCLE_LIMIT = 2200;
    localparam logic [6:0] OPI = 7'b0010011;
    localparam logic [6:0] OPR = 7'b0110011;

    logic clk;
    logic rst_n;
    imem_addr_t imem_addr;
    rv32_instr_t imem_rdata;
    logic dmem_req;
    logic dmem_we;
    dmem_addr_t dmem_addr;
    rv32_data_t dmem_wdata;
    rv32_data_t dmem_rdata;

    rv32_instr_t imem [1024];
    rv32_data_t dmem [1024];
    rv32_data_t exp_mem [1024];
    rv32_instr_t imem_word;
    rv32_data_t dmem_word;
    int pc_word;
    int seed = 2;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int test_errors;
    int cycles = 0;

    pito_core u_pito_core (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // synchronous sram models with data 2 units after the edge
    always @(posedge clk) begin
        imem_word = imem[imem_addr];
        #2 imem_rdata = imem_word;
    end

    always @(posedge clk) begin
        if (dmem_req) begin
            if (dmem_we) begin
                dmem[dmem_addr] = dmem_wdata;
            end
            dmem_word = dmem[dmem_addr];
            #2 dmem_rdata = dmem_word;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: simulation ran past %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    //===========================================================================
    // instruction encoders
    //===========================================================================
    function automatic rv32_instr_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPR};
    endfunction

    function automatic rv32_instr_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv32_instr_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic rv32_instr_t b_type(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic rv32_instr_t u_type(logic [19:0] upper, logic [4:0] rd);
        return {upper, rd, 7'b0110111};
    endfunction

    function automatic rv32_instr_t j_type(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // background word that is unique for every address
    function automatic rv32_data_t fill_word(dmem_addr_t a);
        return {~a, 6'h15, a, 6'h2a};
    endfunction

    task automatic emit(rv32_instr_t ins);
        imem[pc_word] = ins;
        pc_word++;
    endtask

    // lui then addi with the upper part rounded for the sign of the low 12 bits
    task automatic load_const(logic [4:0] rd, rv32_data_t value);
        rv32_data_t upper;
        upper = (value + 32'h800) >> 12;
        emit(u_type(upper[19:0], rd));
        emit(i_type(value[11:0], rd, 3'b000, rd, OPI));
    endtask

    // result lands in x3 and is stored to data word k
    task automatic op_and_store(rv32_instr_t ins, int k, rv32_data_t expected);
        emit(ins);
        emit(s_type(12'(k * 4), 5'd3, 5'd0));
        exp_mem[k] = expected;
    endtask

    //===========================================================================
    // compare tasks
    //===========================================================================
    task automatic check_data(rv32_data_t got, rv32_data_t expected, string what);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("error %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic check_flag(logic got, logic expected, string what);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("error %0t: %s is %b, expected %b", $time, what, got, expected);
        end
    endtask

    //===========================================================================
    // test sequencing
    //===========================================================================
    // assert reset and rebuild both memories once the pipe is cleared
    task automatic begin_test();
        test_errors = errors;
        @(posedge clk);
        #2 rst_n = 1'b0;
        @(posedge clk);
        #2;
        for (int a = 0; a < 1024; a++) begin
            imem[a] = j_type(21'd0, 5'd0);
            dmem[a] = fill_word(dmem_addr_t'(a));
            exp_mem[a] = dmem[a];
        end
        pc_word = 0;
    endtask

    task automatic run_and_compare();
        @(posedge clk);
        #2 rst_n = 1'b1;
        repeat (RUN_CYCLES) @(posedge clk);
        #2;
        for (int a = 0; a < 1024; a++) begin
            check_data(dmem[a], exp_mem[a], $sformatf("dmem word %0d", a));
        end
    endtask

    task automatic end_test(string name);
        tests++;
        $display("test %s finished with %0d errors", name, errors - test_errors);
    endtask

    //===========================================================================
    // directed tests
    //===========================================================================
    task automatic test_reset();
        begin_test();
        // hart 0 opens with a store that must not reach the ports early
        imem[0] = s_type(12'd0, 5'd0, 5'd0);
        check_flag(dmem_req, 1'b0, "dmem_req in reset");
        check_flag(dmem_we, 1'b0, "dmem_we in reset");
        @(posedge clk);
        #2 rst_n = 1'b1;
        repeat (3) begin
            check_flag(dmem_req, 1'b0, "dmem_req after reset");
            check_flag(dmem_we, 1'b0, "dmem_we after reset");
            @(posedge clk);
            #2;
        end
        // the store shows up three cycles after its fetch
        check_flag(dmem_req, 1'b1, "dmem_req of the first store");
        check_flag(dmem_we, 1'b1, "dmem_we of the first store");
        end_test("reset");
    endtask

    task automatic test_alu();
        rv32_data_t a;
        rv32_data_t b;
        logic [11:0] imm;
        rv32_data_t immx;
        a = $random(seed);
        b = $random(seed);
        imm = 12'($random(seed));
        immx = {{20{imm[11]}}, imm};
        begin_test();
        load_const(5'd1, a);
        load_const(5'd2, b);
        op_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 0, a + b);
        op_and_store(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), 1, a - b);
        op_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd3), 2, a & b);
        op_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd3), 3, a | b);
        op_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd3), 4, a ^ b);
        op_and_store(i_type(imm, 5'd1, 3'b000, 5'd3, OPI), 5, a + immx);
        op_and_store(i_type(imm, 5'd1, 3'b111, 5'd3, OPI), 6, a & immx);
        op_and_store(i_type(imm, 5'd1, 3'b110, 5'd3, OPI), 7, a | immx);
        op_and_store(i_type(imm, 5'd1, 3'b100, 5'd3, OPI), 8, a ^ immx);
        run_and_compare();
        end_test("arithmetic and logic");
    endtask

    task automatic test_shift_compare();
        rv32_data_t a;
        rv32_data_t b;
        logic [11:0] imm;
        rv32_data_t immx;
        logic [4:0] sh;
        // a is always negative so sra and srl differ
        a = $random(seed) | 32'h8000_0000;
        b = $random(seed);
        imm = 12'($random(seed));
        immx = {{20{imm[11]}}, imm};
        sh = 5'($random(seed));
        begin_test();
        load_const(5'd1, a);
        load_const(5'd2, b);
        op_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd3), 0,
                     ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        op_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd3), 1, (a < b) ? 32'd1 : 32'd0);
        op_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b001, 5'd3), 2, a << b[4:0]);
        op_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b101, 5'd3), 3, a >> b[4:0]);
        op_and_store(r_type(7'h20, 5'd2, 5'd1, 3'b101, 5'd3), 4, $signed(a) >>> b[4:0]);
        op_and_store(i_type(imm, 5'd1, 3'b010, 5'd3, OPI), 5,
                     ($signed(a) < $signed(immx)) ? 32'd1 : 32'd0);
        op_and_store(i_type(imm, 5'd1, 3'b011, 5'd3, OPI), 6, (a < immx) ? 32'd1 : 32'd0);
        op_and_store(i_type({7'h00, sh}, 5'd1, 3'b001, 5'd3, OPI), 7, a << sh);
        op_and_store(i_type({7'h00, sh}, 5'd1, 3'b101, 5'd3, OPI), 8, a >> sh);
        op_and_store(i_type({7'h20, sh}, 5'd1, 3'b101, 5'd3, OPI), 9, $signed(a) >>> sh);
        run_and_compare();
        end_test("shifts and compares");
    endtask

    task automatic test_load_store();
        rv32_data_t a;
        rv32_data_t b;
        a = $random(seed);
        b = $random(seed);
        begin_test();
        dmem[10] = a;
        dmem[11] = b;
        exp_mem[10] = a;
        exp_mem[11] = b;
        emit(i_type(12'd40, 5'd0, 3'b010, 5'd1, 7'b0000011));
        emit(i_type(12'd44, 5'd0, 3'b010, 5'd2, 7'b0000011));
        op_and_store(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 12, a + b);
        // x0 must stay zero after this write
        emit(i_type(12'h123, 5'd0, 3'b000, 5'd0, OPI));
        emit(s_type(12'd52, 5'd0, 5'd0));
        exp_mem[13] = '0;
        run_and_compare();
        end_test("load and store");
    endtask

    // branch over a marker store so the marker appears only when not taken
    task automatic branch_case(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2, int k,
                               logic taken, rv32_data_t marker);
        emit(b_type(13'd8, rs2, rs1, f3));
        emit(s_type(12'((20 + k) * 4), 5'd5, 5'd0));
        if (!taken) begin
            exp_mem[20 + k] = marker;
        end
    endtask

    task automatic test_control_flow();
        rv32_data_t marker;
        rv32_data_t pc_jump;
        marker = 32'h00c0_ffee;
        begin_test();
        // x1 = 5 and x2 = -3 so x2 < x1 signed and x2 > x1 unsigned
        load_const(5'd1, 32'd5);
        load_const(5'd2, 32'hffff_fffd);
        load_const(5'd5, marker);
        branch_case(3'b000, 5'd1, 5'd1, 0, 1'b1, marker);
        branch_case(3'b001, 5'd1, 5'd2, 1, 1'b1, marker);
        branch_case(3'b100, 5'd2, 5'd1, 2, 1'b1, marker);
        branch_case(3'b101, 5'd1, 5'd2, 3, 1'b1, marker);
        branch_case(3'b110, 5'd1, 5'd2, 4, 1'b1, marker);
        branch_case(3'b111, 5'd2, 5'd1, 5, 1'b1, marker);
        branch_case(3'b000, 5'd1, 5'd2, 6, 1'b0, marker);
        branch_case(3'b001, 5'd1, 5'd1, 7, 1'b0, marker);
        branch_case(3'b100, 5'd1, 5'd2, 8, 1'b0, marker);
        branch_case(3'b101, 5'd2, 5'd1, 9, 1'b0, marker);
        branch_case(3'b110, 5'd2, 5'd1, 10, 1'b0, marker);
        branch_case(3'b111, 5'd1, 5'd2, 11, 1'b0, marker);
        pc_jump = rv32_data_t'(pc_word * 4);
        emit(j_type(21'd8, 5'd6));
        emit(s_type(12'd128, 5'd5, 5'd0));
        emit(s_type(12'd132, 5'd6, 5'd0));
        exp_mem[33] = pc_jump + 4;
        // jalr with offset 1 has bit 0 of its target cleared
        emit(i_type(12'((pc_word + 3) * 4), 5'd0, 3'b000, 5'd7, OPI));
        pc_jump = rv32_data_t'(pc_word * 4);
        emit(i_type(12'd1, 5'd7, 3'b000, 5'd8, 7'b1100111));
        emit(s_type(12'd136, 5'd5, 5'd0));
        emit(s_type(12'd140, 5'd8, 5'd0));
        exp_mem[35] = pc_jump + 4;
        run_and_compare();
        end_test("control flow");
    endtask

    task automatic test_harts();
        hart_id_t hid;
        begin_test();
        for (int h = 0; h < `PITO_NUM_HARTS; h++) begin
            hid = hart_id_t'(h);
            pc_word = h * `PITO_HART_CODE_STRIDE / 4;
            emit(j_type(21'd4, 5'd1));
            emit(i_type(12'd6, 5'd1, 3'b101, 5'd3, OPI));
            emit(i_type(12'd400, 5'd3, 3'b000, 5'd3, OPI));
            emit(i_type(12'h123, 5'd1, 3'b100, 5'd4, OPI));
            emit(s_type(12'd0, 5'd4, 5'd3));
            exp_mem[100 + h] = ({24'd0, hid, 5'd0} * 8 + 32'd4) ^ 32'h123;
        end
        run_and_compare();
        end_test("hart isolation");
    endtask

    initial begin
        rst_n = 1'b0;
        imem_rdata = '0;
        dmem_rdata = '0;
        test_reset();
        test_alu();
        test_shift_compare();
        test_load_store();
        test_control_flow();
        test_harts();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
